/* flist.f */
source/ser_pkg.sv
source/ser_apb_regs.sv
source/ser_rate_gen.sv
source/ser_par2ser.sv
source/ser_tx_top.sv
tb/tb_ser_tx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the serial transmitter testbench with verilator

cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --assert -Wno-fatal -f flist.f \
         --top-module tb_ser_tx --Mdir obj_dir -o sim_ser_tx \
      && ./obj_dir/sim_ser_tx) \
   || { echo "$out"; echo "build or simulation run failed"; exit 1; }

echo "$out"

# pass only if the testbench printed its pass line
echo "$out" | grep -q "TESTS PASSED" && exit 0 || exit 1

/* source/ser_apb_regs.sv */
// apb slave: ctrl, data and status registers with pending-word flag

`timescale 1ns/100ps

module ser_apb_regs (
   input  logic              clk,
   input  logic              nreset,     // async, active low
   input  ser_pkg::apb_req_t apb_req,
   output ser_pkg::apb_rsp_t apb_rsp,
   output ser_pkg::ser_cfg_t cfg,        // live ctrl fields
   output ser_pkg::word_t    word,       // word waiting for the shifter
   output logic              load,       // high while word pending
   input  logic              taken,      // shifter accepted the word
   input  logic              tx_wait     // hold or busy, status only
);
   import ser_pkg::*;

   logic  access;      // second phase of a transfer
   logic  hit_ctrl;
   logic  hit_data;
   logic  hit_status;
   logic  unmapped;
   logic  data_err;    // data write while still pending
   logic  wr_en;
   logic  pending;
   word_t ctrl_rd;
   word_t status_rd;

   //########################################
   // address decode
   //########################################
   assign access     = apb_req.psel & apb_req.penable;
   assign hit_ctrl   = (apb_req.paddr == reg_ctrl);
   assign hit_data   = (apb_req.paddr == reg_data);
   assign hit_status = (apb_req.paddr == reg_status);
   assign unmapped   = ~(hit_ctrl | hit_data | hit_status);
   assign data_err   = hit_data & apb_req.pwrite & pending;

   // rejected writes change nothing
   assign wr_en = access & apb_req.pwrite & ~unmapped & ~data_err;

   //########################################
   // registers
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cfg <= '0;
      end else if (wr_en && hit_ctrl) begin
         cfg.lsbfirst <= apb_req.pwdata[ctrl_lsb_pos];
         cfg.datasize <= apb_req.pwdata[ctrl_size_pos +: cnt_w];
         cfg.clkdiv   <= apb_req.pwdata[ctrl_div_pos +: div_w];
      end
   end

   // data word, payload only
   always_ff @(posedge clk) begin
      if (wr_en && hit_data)
         word <= apb_req.pwdata;
   end

   // set by data write, cleared when the shifter takes it
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         pending <= 1'b0;
      else if (wr_en && hit_data)
         pending <= 1'b1;
      else if (taken)
         pending <= 1'b0;
   end

   assign load = pending;

   //########################################
   // read path and response
   //########################################
   always_comb begin
      ctrl_rd                            = '0;
      ctrl_rd[ctrl_lsb_pos]              = cfg.lsbfirst;
      ctrl_rd[ctrl_size_pos +: cnt_w]    = cfg.datasize;
      ctrl_rd[ctrl_div_pos +: div_w]     = cfg.clkdiv;
   end

   assign status_rd = {{(par_w-2){1'b0}}, tx_wait, pending};

   always_comb begin
      apb_rsp.prdata = '0;
      if (apb_req.psel && !apb_req.pwrite) begin
         if (hit_ctrl)
            apb_rsp.prdata = ctrl_rd;
         else if (hit_status)
            apb_rsp.prdata = status_rd;
         else if (hit_data)
            apb_rsp.prdata = word;       // last word written
      end
      apb_rsp.pready  = 1'b1;           // zero wait states
      apb_rsp.pslverr = access & (unmapped | data_err);
   end

   // shifter only accepts a word this block has flagged
   a_taken_needs_pending : assert property (
      @(posedge clk) disable iff (!nreset) taken |-> pending)
      else $error("taken pulsed with no word pending");

endmodule

/* source/ser_par2ser.sv */
// parallel to serial shifter with bit counter, hold gating and bit order

`timescale 1ns/100ps

module ser_par2ser (
   input  logic              clk,
   input  logic              nreset,
   input  ser_pkg::ser_cfg_t cfg,
   input  ser_pkg::word_t    word,      // parallel data
   input  logic              load,      // word available
   input  logic              shift,     // advance one bit
   input  logic              hold,      // blocks a new start only
   output logic              taken,     // word accepted this cycle
   output logic              ser_data,
   output logic              ser_valid,
   output logic              tx_wait    // hold or busy
);
   import ser_pkg::*;

   bitcnt_t count;   // bits still to send
   word_t   sreg;
   logic    lsb_q;   // order latched per word
   logic    busy;
   logic    start;

   assign busy  = |count;
   assign start = load & ~hold & ~busy;   // never interrupts a word
   assign taken = start;

   //########################################
   // counter and order
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         count <= '0;
         lsb_q <= 1'b0;
      end else if (start) begin
         count <= cfg.datasize;        // zero means empty transfer
         lsb_q <= cfg.lsbfirst;
      end else if (shift && busy) begin
         count <= count - 1'b1;
      end
   end

   //########################################
   // shift register
   //########################################
   always_ff @(posedge clk) begin
      if (start)
         sreg <= word;
      else if (shift && busy) begin
         if (lsb_q)
            sreg <= {{ser_w{1'b0}}, sreg[par_w-1:ser_w]};        // toward bit 0
         else
            sreg <= {sreg[par_w-ser_w-1:0], {ser_w{1'b0}}};      // toward msb
      end
   end

   assign ser_data  = lsb_q ? sreg[0] : sreg[par_w-1];
   assign ser_valid = busy;
   assign tx_wait   = hold | busy;

   // an idle counter only leaves zero through a start
   a_count_no_wrap : assert property (
      @(posedge clk) disable iff (!nreset) (count == '0 && !start) |=> (count == '0))
      else $error("bit counter wrapped below zero");

endmodule

/* source/ser_pkg.sv */
// widths, vector types, register map and bus/config structs for the serial transmitter

package ser_pkg;

   //########################################
   // widths
   //########################################
   localparam int par_w  = 32;     // parallel word
   localparam int ser_w  = 1;      // serial lane, single bit
   localparam int cnt_w  = 5;      // bit counter, up to 31 bits
   localparam int div_w  = 8;      // shift-rate divider
   localparam int addr_w = 4;      // apb byte address

   typedef logic [par_w-1:0]  word_t;
   typedef logic [cnt_w-1:0]  bitcnt_t;   // bits per transfer or bits left
   typedef logic [div_w-1:0]  div_t;
   typedef logic [addr_w-1:0] addr_t;

   //########################################
   // register map
   //########################################
   localparam addr_t reg_ctrl   = 4'h0;
   localparam addr_t reg_data   = 4'h4;
   localparam addr_t reg_status = 4'h8;

   // ctrl field lsb positions
   localparam int ctrl_lsb_pos  = 0;   // bit order
   localparam int ctrl_size_pos = 8;   // datasize, 12..8
   localparam int ctrl_div_pos  = 16;  // clkdiv, 23..16

   typedef struct packed {
      logic    lsbfirst;   // 1 = lsb goes out first
      bitcnt_t datasize;   // 0 sends nothing
      div_t    clkdiv;     // strobe every clkdiv+1 cycles
   } ser_cfg_t;

   typedef struct packed {
      logic  psel;
      logic  penable;
      logic  pwrite;
      addr_t paddr;
      word_t pwdata;
   } apb_req_t;

   typedef struct packed {
      word_t prdata;
      logic  pready;
      logic  pslverr;
   } apb_rsp_t;

endpackage

/* source/ser_rate_gen.sv */
// shift-strobe divider, restarted when a word is taken

`timescale 1ns/100ps

module ser_rate_gen (
   input  logic           clk,
   input  logic           nreset,
   input  ser_pkg::div_t  clkdiv,    // period is clkdiv+1
   input  logic           restart,   // word start, realign the count
   output logic           shift      // one-cycle strobe
);
   import ser_pkg::*;

   div_t cnt;    // cycles until next strobe
   logic run;    // quiet until the first word

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cnt <= '0;
         run <= 1'b0;
      end else begin
         if (restart)
            run <= 1'b1;
         if (restart || cnt == '0)
            cnt <= clkdiv;             // reload
         else
            cnt <= cnt - 1'b1;
      end
   end

   assign shift = run & (cnt == '0);

   // with a divider set, strobes are always separated
   a_no_double_strobe : assert property (
      @(posedge clk) disable iff (!nreset) (shift && clkdiv != '0) |=> !shift)
      else $error("shift strobe high on consecutive cycles");

endmodule

/* source/ser_tx_top.sv */
// top level: apb registers, rate generator and shifter

`timescale 1ns/100ps

module ser_tx_top (
   input  logic              clk,
   input  logic              nreset,
   input  ser_pkg::apb_req_t apb_req,
   output ser_pkg::apb_rsp_t apb_rsp,
   input  logic              hold,        // delays next word start
   output logic              ser_data,
   output logic              ser_valid,
   output logic              ser_shift    // receiver sample strobe
);
   import ser_pkg::*;

   ser_cfg_t cfg;
   word_t    word;
   logic     load;
   logic     taken;
   logic     tx_wait;

   ser_apb_regs u_regs (
      .clk     (clk),
      .nreset  (nreset),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .cfg     (cfg),
      .word    (word),
      .load    (load),
      .taken   (taken),
      .tx_wait (tx_wait)
   );

   // strobe realigned to each word start
   ser_rate_gen u_rate (
      .clk     (clk),
      .nreset  (nreset),
      .clkdiv  (cfg.clkdiv),
      .restart (taken),
      .shift   (ser_shift)
   );

   ser_par2ser u_shift (
      .clk       (clk),
      .nreset    (nreset),
      .cfg       (cfg),
      .word      (word),
      .load      (load),
      .shift     (ser_shift),
      .hold      (hold),
      .taken     (taken),
      .ser_data  (ser_data),
      .ser_valid (ser_valid),
      .tx_wait   (tx_wait)
   );

endmodule

/* tb/ser_tx_patterns.txt */
# name ctrl data hold_cycles expected_bits bit_count second_write_err
# expected_bits is hex, first emitted bit in bit 31; second_write_err 1 tries a refused data write
# ctrl: bit 0 lsbfirst, bits 12..8 datasize, bits 23..16 clkdiv
msb8_div0       00000800 a5c3f00f 0  a5000000 8  0
msb16_div1      00011000 12345678 0  12340000 16 0
msb31_div3      00031f00 deadbeef 0  deadbeee 31 0
msb31_div0      00001f00 7fffffff 0  7ffffffe 31 0
msb12_div1      00010c00 abcdef01 0  abc00000 12 0
msb24_div2      00021800 89abcdef 0  89abcd00 24 0
msb5_div255     00ff0500 f8000000 0  f8000000 5  0
lsb8_div2       00020801 000000b4 0  2d000000 8  0
lsb16_div0      00001001 ffff1234 0  2c480000 16 0
lsb31_div7      00071f01 80000001 0  80000000 31 0
lsb16_div5      00051001 0000ffff 0  ffff0000 16 0
lsb8_div0       00000801 00000001 0  80000000 8  0
lsb4_div3       00030401 0000000d 0  b0000000 4  0
lsb1_div4       00040101 00000001 0  80000000 1  0
hold_msb8       00010800 3c000000 12 3c000000 8  0
hold_lsb12      00000c01 00000abc 5  3d500000 12 0
hold_size0      00000000 12345678 3  00000000 0  0
pending_write   00020c00 0f0f0f0f 6  0f000000 12 1
size0_div3      00030000 ffffffff 0  00000000 0  0
junk_ctrl_bits  ff00eafe c0000000 0  c0000000 10 0

/* tb/tb_ser_tx.sv */
// serial transmitter testbench with clock, reset, apb tasks, pattern reader, checker and report

`timescale 1ns/100ps

module tb_ser_tx;
   import ser_pkg::*;

   localparam int poll_limit  = 10000;   // status polls per word
   localparam int ready_limit = 16;      // cycles to wait for pready
   localparam word_t ctrl_mask = 32'h00ff_1f01;   // implemented ctrl bits

   logic     clk;
   logic     nreset;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;
   logic     hold;
   logic     ser_data;
   logic     ser_valid;
   logic     ser_shift;

   int       cyc = 0;      // free-running cycle count
   int       nbits;        // bits caught in this test
   word_t    bits_got;     // left-aligned in emission order
   int       last_strobe;
   logic     have_last;
   div_t     cur_div;
   string    cur_name;
   int       test_errs;
   int       n_pass;
   int       n_fail;

   ser_tx_top UUT (
      .clk       (clk),
      .nreset    (nreset),
      .apb_req   (apb_req),
      .apb_rsp   (apb_rsp),
      .hold      (hold),
      .ser_data  (ser_data),
      .ser_valid (ser_valid),
      .ser_shift (ser_shift)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   always @(posedge clk) cyc <= cyc + 1;

   //########################################
   // checker and run control
   //########################################
   task automatic check(input string what, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("error %s %s: expected %h actual %h", cur_name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s, in test %s", why, cur_name);
      $display("TESTS FAILED");
      $finish;
   endtask

   task automatic report_test();
      if (test_errs == 0) begin
         $display("test %s ok", cur_name);
         n_pass++;
      end else begin
         $display("test %s failed with %0d errors", cur_name, test_errs);
         n_fail++;
      end
   endtask

   //########################################
   // apb master
   //########################################
   task automatic apb_access(input logic wr, input addr_t addr, input word_t wdata,
                             output word_t rdata, output logic err);
      int n;
      @(posedge clk);
      #1;
      apb_req.psel    = 1'b1;    // setup phase
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(posedge clk);
      #1;
      apb_req.penable = 1'b1;    // access phase
      n = 0;
      @(negedge clk);
      while (!apb_rsp.pready && n < ready_limit) begin
         @(negedge clk);
         n++;
      end
      if (!apb_rsp.pready) begin
         abort_run("apb slave never raised pready");
      end else begin
         rdata = apb_rsp.prdata;
         err   = apb_rsp.pslverr;
         @(posedge clk);            // transfer completes here
         #1;
         apb_req = '0;
      end
   endtask

   task automatic apb_write(input addr_t addr, input word_t wdata, output logic err);
      word_t unused_rd;
      apb_access(1'b1, addr, wdata, unused_rd, err);
   endtask

   task automatic apb_read(input addr_t addr, output word_t rdata, output logic err);
      apb_access(1'b0, addr, '0, rdata, err);
   endtask

   // done means nothing pending and the line quiet
   task automatic wait_idle();
      word_t st;
      logic  err;
      int    n;
      n = 0;
      apb_read(reg_status, st, err);
      while (st != '0 && n < poll_limit) begin
         apb_read(reg_status, st, err);
         n++;
      end
      if (st != '0)
         abort_run("transmitter did not return to idle");
   endtask

   //########################################
   // serial monitor
   //########################################
   always @(negedge clk) begin
      if (nreset && ser_shift && ser_valid) begin
         if (have_last)   // strobe period is clkdiv+1
            check("strobe spacing", word_t'(cur_div) + 32'd1, word_t'(cyc - last_strobe));
         if (nbits < par_w)
            bits_got[par_w-1-nbits] = ser_data;
         nbits++;
         last_strobe = cyc;
         have_last   = 1'b1;
      end
   end

   task automatic run_test(input word_t ctrl, input word_t data, input int hold_cyc,
                           input word_t exp_bits, input int exp_n, input int exp_err);
      word_t rd;
      logic  err;
      logic  err2;
      apb_write(reg_ctrl, ctrl, err);
      check("ctrl pslverr", '0, word_t'(err));
      apb_read(reg_ctrl, rd, err);
      check("ctrl readback", ctrl & ctrl_mask, rd);
      cur_div   = ctrl[23:16];
      nbits     = 0;
      bits_got  = '0;
      have_last = 1'b0;
      if (hold_cyc > 0) begin
         @(posedge clk);
         #1;
         hold = 1'b1;
      end
      apb_write(reg_data, data, err);
      check("data pslverr", '0, word_t'(err));
      if (hold_cyc > 0) begin
         repeat (hold_cyc) begin
            @(negedge clk);
            check("valid under hold", '0, word_t'(ser_valid));
         end
         apb_read(reg_status, rd, err);
         check("status under hold", 32'h3, rd);   // pending and tx_wait
         if (exp_err != 0) begin
            apb_write(reg_data, ~data, err2);      // must be refused
            check("second data pslverr", 32'h1, word_t'(err2));
         end
         @(posedge clk);
         #1;
         hold = 1'b0;
      end
      wait_idle();
      check("valid after word", '0, word_t'(ser_valid));
      check("bit count", word_t'(exp_n), word_t'(nbits));
      check("bits", exp_bits, bits_got);
   endtask

   //########################################
   // main sequence
   //########################################
   initial begin
      int    fd;
      int    nf;
      int    gap;
      int    hold_cyc;
      int    exp_n;
      int    exp_err;
      string line;
      string name;
      word_t ctrl;
      word_t data;
      word_t exp_bits;
      word_t rd;
      logic  err;
      void'($urandom(86));
      apb_req     = '0;
      hold        = 1'b0;
      nreset      = 1'b0;
      n_pass      = 0;
      n_fail      = 0;
      test_errs   = 0;
      nbits       = 0;
      bits_got    = '0;
      have_last   = 1'b0;
      last_strobe = 0;
      cur_div     = '0;
      cur_name    = "reg_map";
      repeat (4) @(posedge clk);
      #1;
      nreset = 1'b1;

      // line quiet and slave ready out of reset
      check("valid after reset", '0, word_t'(ser_valid));
      check("shift after reset", '0, word_t'(ser_shift));
      check("pready after reset", 32'h1, word_t'(apb_rsp.pready));

      // reset values and address decode
      apb_read(reg_ctrl, rd, err);
      check("ctrl after reset", '0, rd);
      apb_read(reg_status, rd, err);
      check("status after reset", '0, rd);
      apb_read(4'hc, rd, err);
      check("unmapped read pslverr", 32'h1, word_t'(err));
      apb_write(4'hc, 32'h1234_5678, err);
      check("unmapped write pslverr", 32'h1, word_t'(err));
      apb_read(reg_status, rd, err);
      check("status after unmapped write", '0, rd);
      report_test();

      fd = $fopen("tb/ser_tx_patterns.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open the pattern file");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            nf = $sscanf(line, "%s %h %h %d %h %d %d",
                         name, ctrl, data, hold_cyc, exp_bits, exp_n, exp_err);
            if (nf == 7) begin   // comment lines fail the scan
               gap = $urandom % 6;
               repeat (gap) @(posedge clk);
               cur_name  = name;
               test_errs = 0;
               run_test(ctrl, data, hold_cyc, exp_bits, exp_n, exp_err);
               report_test();
            end
         end
         $fclose(fd);

         $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
         if (n_fail == 0 && n_pass > 1)
            $display("TESTS PASSED");
         else
            $display("TESTS FAILED");
         $finish;
      end
   end

endmodule
